// File: src/glitch_macros.svh
`ifndef GLITCH_MACROS_SVH
`define GLITCH_MACROS_SVH

// depth of the per-glitch parameter table
`define GLITCH_MAX 32
// bits needed to address one table entry
`define GLITCH_IDX_W 5
// done counter needs to hold num_glitches+1
`define GLITCH_CNT_W (`GLITCH_IDX_W + 1)

// flops on the go feedback path before edge detection
`define GO_SYNC_STAGES 2

// entry word and its field widths
`define GLITCH_WORD_W 32
`define GLITCH_WIDTH_W 8
`define GLITCH_PHASE_W 8
`define GLITCH_LEN_W 16
`define GLITCH_SPARE_W 16

`endif

// File: src/glitch_cfg_pkg.sv
`default_nettype none

`include "glitch_macros.svh"

package glitch_cfg_pkg;

  // global glitch style, picks how a table word is read
  typedef enum logic {
    mode_clock   = 1'b0,
    mode_voltage = 1'b1
  } glitch_mode_e;

  // clock glitch: short pulse after a phase delay
  typedef struct packed {
    logic [`GLITCH_SPARE_W-1:0] spare;
    logic [`GLITCH_PHASE_W-1:0] phase;
    logic [`GLITCH_WIDTH_W-1:0] width;
  } glitch_clk_t;

  // voltage glitch: one long pulse, no delay
  typedef struct packed {
    logic [`GLITCH_SPARE_W-1:0] spare;
    logic [`GLITCH_LEN_W-1:0]   pulse_len;
  } glitch_volt_t;

  // one table word, same bits seen through either decode
  typedef union packed {
    glitch_clk_t               clk;
    glitch_volt_t              volt;
    logic [`GLITCH_WORD_W-1:0] raw;
  } glitch_entry_u;

endpackage

`default_nettype wire

// File: src/glitch_seq_pkg.sv
`default_nettype none

package glitch_seq_pkg;

  // run states of the sequencer
  // st_next is a single cycle between two glitches
  typedef enum logic [1:0] {
    st_idle = 2'd0,
    st_wait = 2'd1,
    st_next = 2'd2,
    st_done = 2'd3
  } seq_state_e;

endpackage

`default_nettype wire

// File: src/glitch_param_table.sv
`timescale 1ns/1ps
`default_nettype none

`include "glitch_macros.svh"

module glitch_param_table
  import glitch_cfg_pkg::*;
(
  input  wire logic                       clk,
  input  wire logic                       exttrig,
  input  wire logic                       cfg_we,
  input  wire logic [`GLITCH_IDX_W-1:0]   cfg_addr,
  input  wire glitch_entry_u              cfg_wdata,
  input  wire logic [`GLITCH_IDX_W-1:0]   fire_index,
  output glitch_entry_u                   fire_entry
);

  // one shape word per glitch index
  glitch_entry_u entries [`GLITCH_MAX];

  // write port, one word per strobe
  always_ff @(posedge clk or posedge exttrig) begin
    if (exttrig) begin
      for (int i = 0; i < `GLITCH_MAX; i++) begin
        entries[i] <= '0;
      end
    end else if (cfg_we) begin
      entries[cfg_addr] <= cfg_wdata;
    end
  end

  // read port follows fire_index without a clock
  // entry is sampled by the pulse generator on fire
  assign fire_entry = entries[fire_index];

endmodule

`default_nettype wire

// File: src/glitch_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

`include "glitch_macros.svh"

module glitch_sequencer
  import glitch_seq_pkg::*;
(
  input  wire logic                       clk,
  input  wire logic                       exttrig,
  input  wire logic                       trig_in,
  input  wire logic [31:0]                offset,
  input  wire logic [`GLITCH_IDX_W-1:0]   num_glitches,
  input  wire logic [`GLITCH_CNT_W-1:0]   done_count,
  output logic                            fire,
  output logic      [`GLITCH_IDX_W-1:0]   fire_index,
  output logic                            done,
  output logic                            idle
);

  seq_state_e                 state;
  logic                       trig_r;
  logic                       trig_latch;
  logic [31:0]                offset_r;
  logic [31:0]                delay_cnt;
  logic [`GLITCH_IDX_W-1:0]   index;
  logic [`GLITCH_CNT_W-1:0]   run_target;
  logic                       fire_cond;

  // offset reached while waiting
  assign fire_cond = (state == st_wait) && (delay_cnt == offset_r);
  // every glitch of the run must come back before we finish
  assign run_target = {1'b0, num_glitches} + 1'b1;
  assign idle = (state == st_idle);

  // input registers and sticky trigger
  always_ff @(posedge clk or posedge exttrig) begin
    if (exttrig) begin
      trig_r     <= 1'b0;
      trig_latch <= 1'b0;
      offset_r   <= '0;
    end else begin
      trig_r   <= trig_in;
      offset_r <= offset;
      // a new trigger sample wins over the clear
      if (trig_r) begin
        trig_latch <= 1'b1;
      end else if (done) begin
        trig_latch <= 1'b0;
      end
    end
  end

  // offset counter and fire strobe
  always_ff @(posedge clk or posedge exttrig) begin
    if (exttrig) begin
      delay_cnt  <= '0;
      fire       <= 1'b0;
      fire_index <= '0;
    end else begin
      if (state == st_wait) begin
        delay_cnt <= delay_cnt + 1'b1;
      end else begin
        delay_cnt <= '0;
      end
      fire <= fire_cond;
      // index of the glitch going out, held until the next fire
      if (fire_cond) begin
        fire_index <= index;
      end
    end
  end

  // run FSM
  always_ff @(posedge clk or posedge exttrig) begin
    if (exttrig) begin
      state <= st_idle;
      done  <= 1'b0;
      index <= '0;
    end else begin
      done <= 1'b0;
      case (state)
        st_idle: begin
          index <= '0;
          // done blocks a restart in the cycle the run closes
          if (trig_latch && !done) begin
            state <= st_wait;
          end
        end
        st_wait: begin
          if (fire_cond) begin
            if (index < num_glitches) begin
              index <= index + 1'b1;
              state <= st_next;
            end else begin
              state <= st_done;
            end
          end
        end
        st_next: begin
          state <= st_wait;
        end
        st_done: begin
          // trigger must drop and every pulse must have ended
          if (!trig_r && (done_count == run_target)) begin
            state <= st_idle;
            done  <= 1'b1;
            index <= '0;
          end
        end
        default: begin
          state <= st_idle;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// File: src/glitch_pulse_gen.sv
`timescale 1ns/1ps
`default_nettype none

`include "glitch_macros.svh"

module glitch_pulse_gen
  import glitch_cfg_pkg::*;
(
  input  wire logic          clk,
  input  wire logic          exttrig,
  input  wire logic          fire,
  input  wire glitch_entry_u fire_entry,
  input  wire glitch_mode_e  glitch_mode,
  output logic               glitch_out
);

  localparam int PH_W  = `GLITCH_PHASE_W;
  localparam int LEN_W = `GLITCH_LEN_W;

  glitch_entry_u    entry_r;
  glitch_mode_e     mode_r;
  logic             load;
  logic             run;
  logic             gap;
  logic             blip;
  logic [PH_W-1:0]  ph_cnt;
  logic [LEN_W-1:0] len_cnt;
  logic [PH_W-1:0]  dec_phase;
  logic [LEN_W-1:0] raw_len;
  logic [LEN_W-1:0] dec_len;
  logic [PH_W-1:0]  cur_ph;
  logic [LEN_W-1:0] cur_len;
  logic             active;
  logic             busy;

  // decode the latched word, voltage mode has no phase delay
  always_comb begin
    if (mode_r == mode_clock) begin
      dec_phase = entry_r.clk.phase;
      raw_len   = LEN_W'(entry_r.clk.width);
    end else begin
      dec_phase = '0;
      raw_len   = entry_r.volt.pulse_len;
    end
    // zero length still gives a one cycle pulse
    dec_len = (raw_len == '0) ? LEN_W'(1) : raw_len;
  end

  // load cycle takes fresh values, later cycles use the counters
  assign cur_ph  = load ? dec_phase : ph_cnt;
  assign cur_len = load ? dec_len : len_cnt;
  assign active  = load | run;
  // anything in flight that a new fire would cut short
  assign busy    = active | gap | blip;
  // blip is the one cycle left to a pulse preempted before it rose
  assign glitch_out = blip | (active & (cur_ph == '0));

  always_ff @(posedge clk or posedge exttrig) begin
    if (exttrig) begin
      entry_r <= '0;
      mode_r  <= mode_clock;
      load    <= 1'b0;
      run     <= 1'b0;
      gap     <= 1'b0;
      blip    <= 1'b0;
      ph_cnt  <= '0;
      len_cnt <= '0;
    end else begin
      // preempt order is blip, gap, load
      // a high pulse skips the blip and drops straight into the gap
      blip <= fire & busy & ~glitch_out;
      gap  <= fire ? (busy & glitch_out) : blip;
      load <= fire ? ~busy : gap;
      if (fire) begin
        entry_r <= fire_entry;
        mode_r  <= glitch_mode;
        run     <= 1'b0;
      end else if (active) begin
        if (cur_ph != '0) begin
          // still in phase delay
          ph_cnt  <= cur_ph - 1'b1;
          len_cnt <= cur_len;
          run     <= 1'b1;
        end else if (cur_len > LEN_W'(1)) begin
          ph_cnt  <= '0;
          len_cnt <= cur_len - 1'b1;
          run     <= 1'b1;
        end else begin
          // last high cycle
          run <= 1'b0;
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: src/go_sync_counter.sv
`timescale 1ns/1ps
`default_nettype none

`include "glitch_macros.svh"

module go_sync_counter (
  input  wire logic                       clk,
  input  wire logic                       exttrig,
  input  wire logic                       glitch_out,
  input  wire logic                       idle,
  output logic      [`GLITCH_CNT_W-1:0]   done_count
);

  logic [`GO_SYNC_STAGES-1:0] go_pipe;
  logic                       go_sync_r;
  logic                       go_fall;

  // high to low on the synchronized go marks one finished glitch
  assign go_fall = go_sync_r & ~go_pipe[`GO_SYNC_STAGES-1];

  always_ff @(posedge clk or posedge exttrig) begin
    if (exttrig) begin
      go_pipe    <= '0;
      go_sync_r  <= 1'b0;
      done_count <= '0;
    end else begin
      // shift in at bit 0, last stage feeds the edge flop
      go_pipe   <= {go_pipe[`GO_SYNC_STAGES-2:0], glitch_out};
      go_sync_r <= go_pipe[`GO_SYNC_STAGES-1];
      if (idle) begin
        done_count <= '0;
      end else if (go_fall) begin
        done_count <= done_count + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: src/glitch_subsystem_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "glitch_macros.svh"

module glitch_subsystem_top
  import glitch_cfg_pkg::*;
(
  input  wire logic                       clk,
  input  wire logic                       exttrig,
  input  wire logic                       trig_in,
  input  wire logic [31:0]                offset,
  input  wire logic [`GLITCH_IDX_W-1:0]   num_glitches,
  input  wire glitch_mode_e               glitch_mode,
  input  wire logic                       cfg_we,
  input  wire logic [`GLITCH_IDX_W-1:0]   cfg_addr,
  input  wire glitch_entry_u              cfg_wdata,
  output logic                            glitch_out,
  output logic                            done,
  output logic                            idle,
  output logic      [`GLITCH_CNT_W-1:0]   done_count
);

  logic                     fire;
  logic [`GLITCH_IDX_W-1:0] fire_index;
  glitch_entry_u            fire_entry;

  // run control
  glitch_sequencer glitch_sequencer_inst (
    .clk          (clk),
    .exttrig      (exttrig),
    .trig_in      (trig_in),
    .offset       (offset),
    .num_glitches (num_glitches),
    .done_count   (done_count),
    .fire         (fire),
    .fire_index   (fire_index),
    .done         (done),
    .idle         (idle)
  );

  // shape words, looked up by the index being fired
  glitch_param_table glitch_param_table_inst (
    .clk        (clk),
    .exttrig    (exttrig),
    .cfg_we     (cfg_we),
    .cfg_addr   (cfg_addr),
    .cfg_wdata  (cfg_wdata),
    .fire_index (fire_index),
    .fire_entry (fire_entry)
  );

  glitch_pulse_gen glitch_pulse_gen_inst (
    .clk         (clk),
    .exttrig     (exttrig),
    .fire        (fire),
    .fire_entry  (fire_entry),
    .glitch_mode (glitch_mode),
    .glitch_out  (glitch_out)
  );

  // feedback of finished pulses to the sequencer
  go_sync_counter go_sync_counter_inst (
    .clk        (clk),
    .exttrig    (exttrig),
    .glitch_out (glitch_out),
    .idle       (idle),
    .done_count (done_count)
  );

endmodule

`default_nettype wire

// File: verification/glitch_properties.sv
`timescale 1ns/1ps
`default_nettype none

module glitch_properties
  import glitch_seq_pkg::*;
#(
  // 1 when bound to the sequencer and 0 when bound to the pulse generator
  parameter bit SEQ_SIDE = 1'b1
) (
  input wire logic       clk,
  input wire logic       exttrig,
  input wire logic       fire,
  input wire logic       done,
  input wire logic       idle,
  input wire seq_state_e state,
  input wire logic       glitch_out
);

  int   fail_cnt = 0;
  logic fired;

  // remembers the first fire since reset
  always_ff @(posedge clk or posedge exttrig) begin
    if (exttrig) begin
      fired <= 1'b0;
    end else if (fire) begin
      fired <= 1'b1;
    end
  end

  if (SEQ_SIDE) begin : g_seq
    // fire follows a wait cycle that moved on to next or done
    fire_after_wait: assert property (@(posedge clk) disable iff (exttrig)
      fire |-> ($past(state) == st_wait) && (state inside {st_next, st_done}))
      else begin
        $error("fire seen outside a wait exit");
        fail_cnt++;
      end
    // done is a single cycle strobe
    done_one_cycle: assert property (@(posedge clk) disable iff (exttrig)
      done |=> !done)
      else begin
        $error("done held for more than one cycle");
        fail_cnt++;
      end
    // the run closes into idle only together with the done strobe
    idle_with_done: assert property (@(posedge clk) disable iff (exttrig)
      $rose(idle) |-> done)
      else begin
        $error("idle returned without done");
        fail_cnt++;
      end
  end else begin : g_pulse
    // no glitch before the first fire
    quiet_until_fire: assert property (@(posedge clk) disable iff (exttrig)
      !fired |-> !glitch_out)
      else begin
        $error("glitch_out high before any fire");
        fail_cnt++;
      end
  end

endmodule

`default_nettype wire

// File: verification/glitch_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "glitch_macros.svh"

module glitch_tb
  import glitch_cfg_pkg::*;
();

  // per test (n+1)*(offset+2+max pulse)+100 with reset counted as one test
  localparam int TIMEOUT_CYCLES = (16 + 100)
    + (1 * (5 + 2 + 9) + 100)
    + (4 * (10 + 2 + 7) + 100)
    + (2 * (4 + 2 + 3) + 100 + 20)
    + (4 * (1 + 2 + 10) + 100)
    + 4 * (4 * (14 + 2 + 8) + 100);

  logic                     clk;
  logic                     exttrig;
  logic                     trig_in;
  logic [31:0]              offset;
  logic [`GLITCH_IDX_W-1:0] num_glitches;
  glitch_mode_e             glitch_mode;
  logic                     cfg_we;
  logic [`GLITCH_IDX_W-1:0] cfg_addr;
  glitch_entry_u            cfg_wdata;
  logic                     glitch_out;
  logic                     done;
  logic                     idle;
  logic [`GLITCH_CNT_W-1:0] done_count;

  int          errors = 0;
  int          tests_passed = 0;
  int          tests_failed = 0;
  int          prop_fails;
  logic [31:0] lfsr_state = 32'h9f37f824;
  // expected shape of each pulse in the current run
  int          exp_len [`GLITCH_MAX];
  int          exp_ph [`GLITCH_MAX];
  // glitch_out edge times in cycles
  int          cyc = 0;
  int          rise_at = 0;
  int          rise_cyc [$];
  int          widths [$];
  logic        out_prev = 1'b0;

  glitch_subsystem_top glitch_subsystem_top_inst (
    .clk          (clk),
    .exttrig      (exttrig),
    .trig_in      (trig_in),
    .offset       (offset),
    .num_glitches (num_glitches),
    .glitch_mode  (glitch_mode),
    .cfg_we       (cfg_we),
    .cfg_addr     (cfg_addr),
    .cfg_wdata    (cfg_wdata),
    .glitch_out   (glitch_out),
    .done         (done),
    .idle         (idle),
    .done_count   (done_count)
  );

  bind glitch_sequencer glitch_properties #(.SEQ_SIDE(1'b1)) seq_props (
    .clk(clk), .exttrig(exttrig), .fire(fire), .done(done), .idle(idle),
    .state(state), .glitch_out(1'b0)
  );
  bind glitch_pulse_gen glitch_properties #(.SEQ_SIDE(1'b0)) pulse_props (
    .clk(clk), .exttrig(exttrig), .fire(fire), .done(1'b0), .idle(1'b0),
    .state(glitch_seq_pkg::st_idle), .glitch_out(glitch_out)
  );

  initial clk = 1'b0;
  always #2 clk = ~clk;

  // edge capture and cycle limit sampled mid cycle
  always @(negedge clk) begin
    cyc++;
    if (!exttrig) begin
      if (glitch_out && !out_prev) begin
        rise_cyc.push_back(cyc);
        rise_at = cyc;
      end
      if (!glitch_out && out_prev) begin
        widths.push_back(cyc - rise_at);
      end
    end
    out_prev = glitch_out;
    if (cyc >= TIMEOUT_CYCLES) begin
      $display("timeout: no end of tests after %0d cycles", TIMEOUT_CYCLES);
      $display("*** FAILED ***");
      $finish;
    end
  end

  // right shifting Galois LFSR with taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  function automatic int take_bits(input int nbits);
    int value;
    value = 0;
    for (int i = 0; i < nbits; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      value = (value << 1) | int'(lfsr_state[0]);
    end
    return value;
  endfunction

  function automatic glitch_entry_u clk_entry(input int width, input int phase);
    glitch_entry_u e;
    e.raw       = '0;
    e.clk.width = 8'(width);
    e.clk.phase = 8'(phase);
    return e;
  endfunction

  function automatic glitch_entry_u volt_entry(input int len);
    glitch_entry_u e;
    e.raw            = '0;
    e.volt.pulse_len = 16'(len);
    return e;
  endfunction

  task automatic check_value(input string name, input int expected, input int actual);
    assert (expected == actual) else begin
      $display("[ERROR] %0t %s expected %0d actual %0d", $time, name, expected, actual);
      errors++;
    end
  endtask

  task automatic report_test(input string name, input int errs_before);
    if (errors == errs_before) begin
      tests_passed++;
      $display("[PASS] %s", name);
    end else begin
      tests_failed++;
      $display("[FAIL] %s with %0d errors", name, errors - errs_before);
    end
  endtask

  task automatic check_quiet();
    check_value("glitch_out", 0, glitch_out);
    check_value("done", 0, done);
    check_value("idle", 1, idle);
    check_value("done_count", 0, done_count);
  endtask

  task automatic write_entry(input int idx, input glitch_entry_u word);
    @(posedge clk);
    #1;
    cfg_we    = 1'b1;
    cfg_addr  = idx[`GLITCH_IDX_W-1:0];
    cfg_wdata = word;
    @(posedge clk);
    #1;
    cfg_we = 1'b0;
  endtask

  // run settings and an empty capture
  task automatic configure_run(input glitch_mode_e mode, input int n, input int off);
    @(posedge clk);
    #1;
    glitch_mode  = mode;
    num_glitches = n[`GLITCH_IDX_W-1:0];
    offset       = off;
    rise_cyc.delete();
    widths.delete();
  endtask

  task automatic pulse_trigger();
    @(posedge clk);
    #1;
    trig_in = 1'b1;
    @(posedge clk);
    #1;
    trig_in = 1'b0;
  endtask

  // done strobe then one settled cycle back in idle
  task automatic wait_done();
    do @(negedge clk); while (!done);
    // every fired glitch is counted back when done shows
    check_value("done_count", num_glitches + 1, done_count);
    @(negedge clk);
    check_quiet();
  endtask

  // count, width and rise spacing of every pulse in the run
  task automatic check_run(input int n, input int off);
    check_value("glitch_out rises", n + 1, rise_cyc.size());
    check_value("glitch_out falls", n + 1, widths.size());
    if (rise_cyc.size() == n + 1 && widths.size() == n + 1) begin
      for (int i = 0; i <= n; i++) begin
        check_value($sformatf("glitch_out width[%0d]", i), exp_len[i], widths[i]);
        if (i > 0) begin
          check_value($sformatf("glitch_out spacing[%0d]", i),
                      off + 2 + exp_ph[i] - exp_ph[i-1], rise_cyc[i] - rise_cyc[i-1]);
        end
      end
    end
  endtask

  task automatic test_reset();
    int errs_before;
    errs_before = errors;
    repeat (8) @(posedge clk);
    @(negedge clk);
    check_quiet();
    repeat (8) @(posedge clk);
    #1;
    exttrig = 1'b0;
    repeat (4) @(negedge clk);
    check_quiet();
    report_test("reset state", errs_before);
  endtask

  task automatic test_single_clock();
    int errs_before;
    errs_before = errors;
    write_entry(0, clk_entry(6, 3));
    exp_len[0] = 6;
    exp_ph[0]  = 3;
    configure_run(mode_clock, 0, 5);
    pulse_trigger();
    wait_done();
    check_run(0, 5);
    report_test("single clock glitch", errs_before);
  endtask

  task automatic test_multi_voltage();
    int errs_before;
    int lens [4];
    errs_before = errors;
    lens = '{3, 5, 2, 7};
    for (int i = 0; i < 4; i++) begin
      write_entry(i, volt_entry(lens[i]));
      exp_len[i] = lens[i];
      exp_ph[i]  = 0;
    end
    configure_run(mode_voltage, 3, 10);
    pulse_trigger();
    wait_done();
    check_run(3, 10);
    report_test("multiple voltage glitches", errs_before);
  endtask

  task automatic test_trigger_held();
    int errs_before;
    errs_before = errors;
    for (int i = 0; i < 2; i++) begin
      write_entry(i, volt_entry(3));
      exp_len[i] = 3;
      exp_ph[i]  = 0;
    end
    configure_run(mode_voltage, 1, 4);
    trig_in = 1'b1;
    while (widths.size() < 2) @(negedge clk);
    // done must wait for the trigger to drop even with all glitches back
    repeat (20) begin
      @(negedge clk);
      check_value("done", 0, done);
    end
    @(posedge clk);
    #1;
    trig_in = 1'b0;
    wait_done();
    check_run(1, 4);
    report_test("trigger held high", errs_before);
  endtask

  task automatic test_preempt();
    int errs_before;
    errs_before = errors;
    for (int i = 0; i < 4; i++) begin
      write_entry(i, volt_entry(10));
    end
    // spacing of 3 cuts every pulse but the last
    configure_run(mode_voltage, 3, 1);
    pulse_trigger();
    wait_done();
    check_value("glitch_out falls", 4, widths.size());
    if (widths.size() == 4) begin
      check_value("glitch_out width[3]", 10, widths[3]);
    end
    report_test("preemption", errs_before);
  endtask

  task automatic test_random_runs();
    int            errs_before;
    int            n;
    int            off;
    int            w;
    int            ph;
    glitch_mode_e  mode;
    glitch_entry_u e;
    errs_before = errors;
    for (int r = 0; r < 4; r++) begin
      mode = glitch_mode_e'(take_bits(1));
      n    = take_bits(2);
      // offset 7..14 keeps phase+width within offset+1
      off  = 7 + take_bits(3);
      for (int i = 0; i <= n; i++) begin
        e.raw       = '0;
        e.clk.spare = 16'(take_bits(16));
        if (mode == mode_clock) begin
          w           = take_bits(2);
          ph          = take_bits(2);
          e.clk.width = 8'(w);
          e.clk.phase = 8'(ph);
        end else begin
          w                = take_bits(3);
          ph               = 0;
          e.volt.pulse_len = 16'(w);
        end
        // zero length still gives one cycle
        exp_len[i] = (w == 0) ? 1 : w;
        exp_ph[i]  = ph;
        write_entry(i, e);
      end
      configure_run(mode, n, off);
      pulse_trigger();
      wait_done();
      check_run(n, off);
    end
    report_test("random runs", errs_before);
  endtask

  initial begin
    exttrig      = 1'b1;
    trig_in      = 1'b0;
    offset       = '0;
    num_glitches = '0;
    glitch_mode  = mode_clock;
    cfg_we       = 1'b0;
    cfg_addr     = '0;
    cfg_wdata    = '0;
    test_reset();
    test_single_clock();
    test_multi_voltage();
    test_trigger_held();
    test_preempt();
    test_random_runs();
    prop_fails = glitch_subsystem_top_inst.glitch_sequencer_inst.seq_props.fail_cnt
               + glitch_subsystem_top_inst.glitch_pulse_gen_inst.pulse_props.fail_cnt;
    if (prop_fails != 0) begin
      $display("bound assertions failed %0d times", prop_fails);
    end
    $display("tests passed %0d failed %0d", tests_passed, tests_failed);
    if (errors == 0 && tests_failed == 0 && prop_fails == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+src
src/glitch_cfg_pkg.sv
src/glitch_seq_pkg.sv
src/glitch_param_table.sv
src/glitch_sequencer.sv
src/glitch_pulse_gen.sv
src/go_sync_counter.sv
src/glitch_subsystem_top.sv
verification/glitch_properties.sv
verification/glitch_tb.sv
